//--- dv/mem_subsystem_tb.sv
module mem_subsystem_tb;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic        clock;
    logic        reset;
    logic        exu_valid;
    exu_req_t    exu_req;
    logic        exu_ready;
    logic        fetch_valid;
    lsu_read_t   fetch_read;
    logic        fetch_ready;
    logic [31:0] fetch_data;
    csr_write_t  csr_write;
    logic [4:0]  dbg_raddr;
    logic [31:0] dbg_rdata;

    int          seed;
    int          errors;
    int          timeouts;
    int          exu_wait;
    logic        fetch_at_accept;
    csr_write_t  csr_seen;
    // byte-addressed reference image of the SRAM
    logic [7:0]  model_mem [4096];

    mem_subsystem_top #(
        .SRAM_WORDS   (1024),
        .SRAM_LATENCY (2)
    ) i_mem_subsystem_top (
        .clock, .reset,
        .exu_valid, .exu_req, .exu_ready,
        .fetch_valid, .fetch_read, .fetch_ready, .fetch_data,
        .csr_write,
        .dbg_raddr, .dbg_rdata
    );

    always #5 clock = ~clock;

    // ----------------------------------------------------------
    // reporting
    // ----------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
        timeouts++;
        finish_run();
    endtask

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return {model_mem[{addr[11:2], 2'd3}], model_mem[{addr[11:2], 2'd2}],
                model_mem[{addr[11:2], 2'd1}], model_mem[{addr[11:2], 2'd0}]};
    endfunction

    // lane select plus sign or zero extension
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input access_size_t size,
                                                  input logic is_signed);
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        byte_val = model_mem[addr[11:0]];
        half_val = {model_mem[{addr[11:1], 1'b1}], model_mem[{addr[11:1], 1'b0}]};
        case (size)
            SIZE_BYTE: return {{24{is_signed & byte_val[7]}}, byte_val};
            SIZE_HALF: return {{16{is_signed & half_val[15]}}, half_val};
            default:   return model_word(addr);
        endcase
    endfunction

    // ----------------------------------------------------------
    // drive tasks
    // ----------------------------------------------------------

    task automatic send_exu(input exu_req_t req);
        int waited;
        waited = 0;
        @(posedge clock);
        #1;
        exu_valid = 1'b1;
        exu_req   = req;
        @(negedge clock);
        while (!exu_ready && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clock);
        end
        if (!exu_ready) begin
            abort_on_timeout("exu_ready");
        end else begin
            // snapshot of the acceptance cycle
            exu_wait        = waited;
            fetch_at_accept = fetch_valid;
            csr_seen        = csr_write;
            @(posedge clock);
            #1;
            exu_valid = 1'b0;
            exu_req   = '0;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!exu_ready && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clock);
        end
        if (!exu_ready) begin
            abort_on_timeout("end of memory operation");
        end
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] value);
        @(posedge clock);
        #1;
        dbg_raddr = addr;
        @(negedge clock);
        value = dbg_rdata;
    endtask

    task automatic store_mem(input logic [31:0] addr, input logic [31:0] data,
                             input access_size_t size);
        exu_req_t req;
        req        = '0;
        req.mem_en = 1'b1;
        req.write  = 1'b1;
        req.size   = size;
        req.addr   = addr;
        req.wdata  = data;
        send_exu(req);
        wait_idle();
        case (size)
            SIZE_BYTE: model_mem[addr[11:0]] = data[7:0];
            SIZE_HALF: begin
                model_mem[{addr[11:1], 1'b0}] = data[7:0];
                model_mem[{addr[11:1], 1'b1}] = data[15:8];
            end
            default: begin
                model_mem[{addr[11:2], 2'd0}] = data[7:0];
                model_mem[{addr[11:2], 2'd1}] = data[15:8];
                model_mem[{addr[11:2], 2'd2}] = data[23:16];
                model_mem[{addr[11:2], 2'd3}] = data[31:24];
            end
        endcase
    endtask

    task automatic load_and_check(input string name, input logic [31:0] addr,
                                  input access_size_t size, input logic is_signed,
                                  input logic [4:0] rd);
        exu_req_t    req;
        logic [31:0] value;
        req             = '0;
        req.mem_en      = 1'b1;
        req.size        = size;
        req.load_signed = is_signed;
        req.addr        = addr;
        req.rd_addr     = rd;
        send_exu(req);
        wait_idle();
        read_reg(rd, value);
        check_value(name, expected_load(addr, size, is_signed), value);
    endtask

    // fetch_valid stays high until the last beat
    task automatic do_fetch(input string name, input logic [31:0] addr,
                            input logic [7:0] len);
        int beats;
        int waited;
        beats  = 0;
        waited = 0;
        @(posedge clock);
        #1;
        fetch_valid      = 1'b1;
        fetch_read       = '0;
        fetch_read.addr  = addr;
        fetch_read.len   = len;
        fetch_read.burst = 1'b1;
        while (beats <= int'(len) && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            if (fetch_ready) begin
                check_value(name, model_word(addr + 32'(4 * beats)), fetch_data);
                beats++;
            end else begin
                waited++;
            end
        end
        if (beats <= int'(len)) begin
            abort_on_timeout("fetch beat");
        end else begin
            @(posedge clock);
            #1;
            fetch_valid = 1'b0;
            fetch_read  = '0;
        end
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------

    task automatic test_reg_writeback();
        exu_req_t    req;
        logic [31:0] written [5];
        logic [31:0] value;
        for (int i = 0; i < 5; i++) begin
            written[i]  = $random(seed);
            req         = '0;
            req.rd_en   = 1'b1;
            req.rd_addr = 5'(3 * (i + 1));
            req.rd_data = written[i];
            send_exu(req);
        end
        for (int i = 0; i < 5; i++) begin
            read_reg(5'(3 * (i + 1)), value);
            check_value("reg_writeback", written[i], value);
        end
        req         = '0;
        req.rd_en   = 1'b1;
        req.rd_data = $random(seed);
        send_exu(req);
        read_reg(5'd0, value);
        check_value("reg_writeback x0", 32'd0, value);
    endtask

    task automatic test_csr_write();
        exu_req_t req;
        req          = '0;
        req.csr_en   = 1'b1;
        req.csr_addr = 12'h305;
        req.csr_data = $random(seed);
        send_exu(req);
        check_value("csr_write en", 32'd1, 32'(csr_seen.en));
        check_value("csr_write addr", 32'h305, 32'(csr_seen.addr));
        check_value("csr_write data", req.csr_data, csr_seen.data);
    endtask

    task automatic test_word_access();
        for (int i = 0; i < 6; i++) begin
            store_mem(32'h40 + 32'(12 * i), $random(seed), SIZE_WORD);
        end
        for (int i = 0; i < 6; i++) begin
            load_and_check("word_load", 32'h40 + 32'(12 * i), SIZE_WORD, 1'b0, 5'(10 + i));
        end
    endtask

    task automatic test_byte_half();
        store_mem(32'h100, 32'h80f1_7f22, SIZE_WORD);
        store_mem(32'h101, 32'h0000_00a5, SIZE_BYTE);
        store_mem(32'h102, 32'h0000_9c3e, SIZE_HALF);
        load_and_check("lb lane1", 32'h101, SIZE_BYTE, 1'b1, 5'd21);
        load_and_check("lbu lane1", 32'h101, SIZE_BYTE, 1'b0, 5'd22);
        load_and_check("lb lane0", 32'h100, SIZE_BYTE, 1'b1, 5'd23);
        load_and_check("lbu lane3", 32'h103, SIZE_BYTE, 1'b0, 5'd24);
        load_and_check("lh upper", 32'h102, SIZE_HALF, 1'b1, 5'd25);
        load_and_check("lhu upper", 32'h102, SIZE_HALF, 1'b0, 5'd26);
        load_and_check("lh lower", 32'h100, SIZE_HALF, 1'b1, 5'd27);
        load_and_check("lw merged", 32'h100, SIZE_WORD, 1'b0, 5'd28);
    endtask

    task automatic test_burst_fetch();
        for (int i = 0; i < 8; i++) begin
            store_mem(32'h200 + 32'(4 * i), $random(seed), SIZE_WORD);
        end
        do_fetch("burst_fetch", 32'h200, 8'd7);
    endtask

    task automatic test_fetch_priority();
        fork
            do_fetch("priority_fetch", 32'h200, 8'd3);
            begin
                repeat (2) @(posedge clock);
                load_and_check("priority_load", 32'h204, SIZE_WORD, 1'b0, 5'd30);
            end
        join
        // the load must have stalled behind the fetch
        check_value("priority_stalled", 32'd1, 32'(exu_wait > 0));
        check_value("priority_order", 32'd0, 32'(fetch_at_accept));
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        exu_valid       = 1'b0;
        exu_req         = '0;
        fetch_valid     = 1'b0;
        fetch_read      = '0;
        dbg_raddr       = 5'd0;
        seed            = 50;
        errors          = 0;
        timeouts        = 0;
        exu_wait        = 0;
        fetch_at_accept = 1'b0;
        csr_seen        = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reg_writeback();
        test_csr_write();
        test_word_access();
        test_byte_half();
        test_burst_fetch();
        test_fetch_priority();
        finish_run();
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module mem_subsystem_tb -o sim_mem > build.log 2>&1 \
    && ./obj_dir/sim_mem > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
    && { echo "run passed"; exit 0; } \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

//--- sources.f
src/mem_pkg.sv
src/mem_arbiter.sv
src/load_store_unit.sv
src/data_sram.sv
src/reg_file.sv
src/mem_subsystem_top.sv
dv/mem_subsystem_tb.sv

//--- src/data_sram.sv
module data_sram #(
    parameter int SRAM_WORDS   = 1024,
    parameter int SRAM_LATENCY = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req,
    input  logic                          we,
    input  logic [$clog2(SRAM_WORDS)-1:0] addr,
    input  logic [3:0]                    byte_en,
    input  logic [31:0]                   wdata,
    output logic                          rvalid,
    output logic [31:0]                   rdata
);

    logic [3:0][7:0]  mem [SRAM_WORDS];
    logic [SRAM_LATENCY-1:0] valid_pipe;
    logic [31:0]      data_pipe [SRAM_LATENCY];

    // byte-enabled write port
    always_ff @(posedge clock) begin
        if (req && we) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[addr][b] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // read delay line
    // ----------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= req & ~we;
            for (int i = 1; i < SRAM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        data_pipe[0] <= mem[addr];
        for (int i = 1; i < SRAM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rvalid = valid_pipe[SRAM_LATENCY-1];
    assign rdata  = data_pipe[SRAM_LATENCY-1];

endmodule

//--- src/load_store_unit.sv
module load_store_unit #(
    parameter int SRAM_WORDS   = 1024,
    parameter int SRAM_LATENCY = 2
) (
    input  logic                          clock,
    input  logic                          reset,

    input  logic                          rd_valid,
    input  mem_pkg::lsu_read_t            rd_cmd,
    output logic                          rd_ready,
    output logic [31:0]                   rd_data,

    input  logic                          wr_valid,
    input  mem_pkg::lsu_write_t           wr_cmd,
    output logic                          wr_ready,

    output logic                          sram_req,
    output logic                          sram_we,
    output logic [$clog2(SRAM_WORDS)-1:0] sram_addr,
    output logic [3:0]                    sram_byte_en,
    output logic [31:0]                   sram_wdata,
    input  logic                          sram_rvalid,
    input  logic [31:0]                   sram_rdata
);
    import mem_pkg::*;

    localparam int ADDR_W = $clog2(SRAM_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_WAIT,
        ST_WRITE_DONE
    } lsu_state_t;

    lsu_state_t        state;
    logic [7:0]        beat_cnt;
    logic [ADDR_W-1:0] beat_addr;
    logic              start_read;
    logic              start_write;
    logic              last_beat;
    logic              next_beat;

    // pick the addressed lane, then extend to 32 bits
    function automatic logic [31:0] extend_load(input logic [31:0] word,
                                                input logic [1:0] offset,
                                                input access_size_t size,
                                                input logic is_signed);
        logic [31:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (size)
            SIZE_BYTE: return {{24{is_signed & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: return {{16{is_signed & shifted[15]}}, shifted[15:0]};
            default:   return shifted;
        endcase
    endfunction

    // reads take precedence when both are offered
    assign start_read  = (state == ST_IDLE) & rd_valid;
    assign start_write = (state == ST_IDLE) & ~rd_valid & wr_valid;
    assign last_beat   = beat_cnt == rd_cmd.len;
    assign next_beat   = (state == ST_READ_WAIT) & rd_ready & ~last_beat;

    assign sram_req = start_read | start_write | next_beat;
    assign sram_we  = start_write;
    assign wr_ready = state == ST_WRITE_DONE;

    always_comb begin
        if (start_read) begin
            sram_addr = rd_cmd.addr[ADDR_W+1:2];
        end else if (start_write) begin
            sram_addr = wr_cmd.addr[ADDR_W+1:2];
        end else if (rd_cmd.burst) begin
            sram_addr = beat_addr + 1'b1;
        end else begin
            sram_addr = beat_addr;
        end
    end

    // ----------------------------------------------------------
    // store lane placement
    // ----------------------------------------------------------

    always_comb begin
        case (wr_cmd.size)
            SIZE_BYTE: begin
                sram_wdata   = {4{wr_cmd.data[7:0]}};
                sram_byte_en = 4'b0001 << wr_cmd.addr[1:0];
            end
            SIZE_HALF: begin
                sram_wdata   = {2{wr_cmd.data[15:0]}};
                sram_byte_en = wr_cmd.addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                sram_wdata   = wr_cmd.data;
                sram_byte_en = 4'b1111;
            end
        endcase
    end

    // ----------------------------------------------------------
    // sequencing
    // ----------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_IDLE;
            rd_ready <= 1'b0;
            beat_cnt <= 8'd0;
        end else begin
            rd_ready <= (state == ST_READ_WAIT) & sram_rvalid;
            if (start_read) begin
                beat_cnt <= 8'd0;
            end else if (next_beat) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
            case (state)
                ST_IDLE: begin
                    if (start_read) begin
                        state <= ST_READ_WAIT;
                    end else if (start_write) begin
                        state <= ST_WRITE_DONE;
                    end
                end
                ST_READ_WAIT: begin
                    if (rd_ready && last_beat) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start_read || next_beat) begin
            beat_addr <= sram_addr;
        end
        if (sram_rvalid) begin
            rd_data <= extend_load(sram_rdata, rd_cmd.addr[1:0], rd_cmd.size,
                                   rd_cmd.load_signed);
        end
    end

    a_rvalid_not_idle: assert property (@(posedge clock) disable iff (reset)
        sram_rvalid |-> state != ST_IDLE);

    // memory answers a read after exactly its configured latency
    a_read_latency: assert property (@(posedge clock) disable iff (reset)
        sram_req && !sram_we |-> ##SRAM_LATENCY sram_rvalid);

endmodule

//--- src/mem_arbiter.sv
module mem_arbiter (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 exu_valid,
    input  mem_pkg::exu_req_t    exu_req,
    output logic                 exu_ready,

    input  logic                 fetch_valid,
    input  mem_pkg::lsu_read_t   fetch_read,
    output logic                 fetch_ready,
    output logic [31:0]          fetch_data,

    output logic                 rd_valid,
    output mem_pkg::lsu_read_t   rd_cmd,
    input  logic                 rd_ready,
    input  logic [31:0]          rd_data,

    output logic                 wr_valid,
    output mem_pkg::lsu_write_t  wr_cmd,
    input  logic                 wr_ready,

    output mem_pkg::reg_write_t  reg_write,
    output mem_pkg::csr_write_t  csr_write
);
    import mem_pkg::*;

    logic       busy;
    logic       ld_valid;
    logic       st_valid;
    lsu_read_t  ld_cmd;
    lsu_write_t st_cmd;
    logic [4:0] ld_rd_addr;
    logic       fetch_sel;
    logic       accept;
    logic       mem_accept;
    logic       op_done;

    // ----------------------------------------------------------
    // handshake and steering
    // ----------------------------------------------------------

    // fetch owns the read channel only while no data op is held
    assign fetch_sel  = ~busy & fetch_valid;
    assign exu_ready  = ~busy & ~(fetch_valid & exu_req.mem_en);
    assign accept     = exu_valid & exu_ready;
    assign mem_accept = accept & exu_req.mem_en;
    assign op_done    = (ld_valid & rd_ready) | (st_valid & wr_ready);

    assign rd_valid = fetch_sel | ld_valid;
    assign wr_valid = st_valid;
    assign wr_cmd   = st_cmd;

    always_comb begin
        if (fetch_sel) begin
            rd_cmd             = fetch_read;
            rd_cmd.size        = SIZE_WORD;
            rd_cmd.load_signed = 1'b0;
        end else begin
            rd_cmd = ld_cmd;
        end
    end

    assign fetch_ready = fetch_sel & rd_ready;
    assign fetch_data  = fetch_sel ? rd_data : 32'd0;

    // ----------------------------------------------------------
    // writeback
    // ----------------------------------------------------------

    // load result has priority over direct register writes
    always_comb begin
        if (ld_valid) begin
            reg_write.en   = rd_ready;
            reg_write.addr = ld_rd_addr;
            reg_write.data = rd_data;
        end else begin
            reg_write.en   = accept & ~exu_req.mem_en & exu_req.rd_en;
            reg_write.addr = exu_req.rd_addr;
            reg_write.data = exu_req.rd_data;
        end
    end

    assign csr_write.en   = accept & exu_req.csr_en;
    assign csr_write.addr = exu_req.csr_addr;
    assign csr_write.data = exu_req.csr_data;

    // ----------------------------------------------------------
    // held memory operation
    // ----------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            ld_valid <= 1'b0;
            st_valid <= 1'b0;
        end else if (mem_accept) begin
            busy     <= 1'b1;
            ld_valid <= ~exu_req.write;
            st_valid <= exu_req.write;
        end else if (op_done) begin
            busy     <= 1'b0;
            ld_valid <= 1'b0;
            st_valid <= 1'b0;
        end
    end

    // single beat for every data access
    always_ff @(posedge clock) begin
        if (mem_accept) begin
            ld_cmd.addr        <= exu_req.addr;
            ld_cmd.len         <= 8'd0;
            ld_cmd.burst       <= 1'b0;
            ld_cmd.size        <= exu_req.size;
            ld_cmd.load_signed <= exu_req.load_signed;
            ld_rd_addr         <= exu_req.rd_addr;
            st_cmd.addr        <= exu_req.addr;
            st_cmd.data        <= exu_req.wdata;
            st_cmd.size        <= exu_req.size;
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    a_one_channel: assert property (@(posedge clock) disable iff (reset)
        !(rd_valid && wr_valid));

    // a new data op never lands while the load/store unit still answers
    a_no_accept_busy: assert property (@(posedge clock) disable iff (reset)
        mem_accept |-> !(rd_ready || wr_ready));

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    // ----------------------------------------------------------
    // access size
    // ----------------------------------------------------------

    // all ones is a full word, same as the fetch path
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b11
    } access_size_t;

    // ----------------------------------------------------------
    // execute stage request
    // ----------------------------------------------------------

    typedef struct packed {
        logic         mem_en;
        logic         write;
        logic         load_signed;
        access_size_t size;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [4:0]   rd_addr;
        logic [31:0]  rd_data;
        logic         rd_en;
        logic [11:0]  csr_addr;
        logic [31:0]  csr_data;
        logic         csr_en;
    } exu_req_t;

    // ----------------------------------------------------------
    // load/store unit commands
    // ----------------------------------------------------------

    // len counts beats minus one
    typedef struct packed {
        logic [31:0]  addr;
        logic [7:0]   len;
        logic         burst;
        access_size_t size;
        logic         load_signed;
    } lsu_read_t;

    typedef struct packed {
        logic [31:0]  addr;
        logic [31:0]  data;
        access_size_t size;
    } lsu_write_t;

    // ----------------------------------------------------------
    // writeback
    // ----------------------------------------------------------

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_write_t;

endpackage

//--- src/mem_subsystem_top.sv
module mem_subsystem_top #(
    parameter int SRAM_WORDS   = 1024,
    parameter int SRAM_LATENCY = 2
) (
    input  logic                clock,
    input  logic                reset,

    input  logic                exu_valid,
    input  mem_pkg::exu_req_t   exu_req,
    output logic                exu_ready,

    input  logic                fetch_valid,
    input  mem_pkg::lsu_read_t  fetch_read,
    output logic                fetch_ready,
    output logic [31:0]         fetch_data,

    output mem_pkg::csr_write_t csr_write,

    input  logic [4:0]          dbg_raddr,
    output logic [31:0]         dbg_rdata
);
    import mem_pkg::*;

    localparam int ADDR_W = $clog2(SRAM_WORDS);

    // arbiter to load/store unit
    logic        rd_valid;
    lsu_read_t   rd_cmd;
    logic        rd_ready;
    logic [31:0] rd_data;
    logic        wr_valid;
    lsu_write_t  wr_cmd;
    logic        wr_ready;
    reg_write_t  reg_write;

    // load/store unit to memory
    logic              sram_req;
    logic              sram_we;
    logic [ADDR_W-1:0] sram_addr;
    logic [3:0]        sram_byte_en;
    logic [31:0]       sram_wdata;
    logic              sram_rvalid;
    logic [31:0]       sram_rdata;

    mem_arbiter i_mem_arbiter (
        .clock, .reset,
        .exu_valid, .exu_req, .exu_ready,
        .fetch_valid, .fetch_read, .fetch_ready, .fetch_data,
        .rd_valid, .rd_cmd, .rd_ready, .rd_data,
        .wr_valid, .wr_cmd, .wr_ready,
        .reg_write, .csr_write
    );

    load_store_unit #(
        .SRAM_WORDS   (SRAM_WORDS),
        .SRAM_LATENCY (SRAM_LATENCY)
    ) i_load_store_unit (
        .clock, .reset,
        .rd_valid, .rd_cmd, .rd_ready, .rd_data,
        .wr_valid, .wr_cmd, .wr_ready,
        .sram_req, .sram_we, .sram_addr, .sram_byte_en, .sram_wdata,
        .sram_rvalid, .sram_rdata
    );

    data_sram #(
        .SRAM_WORDS   (SRAM_WORDS),
        .SRAM_LATENCY (SRAM_LATENCY)
    ) i_data_sram (
        .clock, .reset,
        .req     (sram_req),
        .we      (sram_we),
        .addr    (sram_addr),
        .byte_en (sram_byte_en),
        .wdata   (sram_wdata),
        .rvalid  (sram_rvalid),
        .rdata   (sram_rdata)
    );

    reg_file i_reg_file (
        .clock, .reset,
        .reg_write,
        .raddr (dbg_raddr),
        .rdata (dbg_rdata)
    );

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic                clock,
    input  logic                reset,
    input  mem_pkg::reg_write_t reg_write,
    input  logic [4:0]          raddr,
    output logic [31:0]         rdata
);

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------

    // x0 has no storage
    logic [31:0] regs [1:31];
    logic        write_ok;

    assign write_ok = reg_write.en & (reg_write.addr != 5'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_ok) begin
            regs[reg_write.addr] <= reg_write.data;
        end
    end

    // ----------------------------------------------------------
    // read port
    // ----------------------------------------------------------

    // asynchronous, sees a write only after its edge
    always_comb begin
        if (raddr == 5'd0) begin
            rdata = 32'd0;
        end else begin
            rdata = regs[raddr];
        end
    end

endmodule
